// ==== build.f ====
source/tomasulo_pkg.sv
source/dispatch_if.sv
source/issue_unit.sv
source/rename_regfile.sv
source/reorder_buffer.sv
source/reservation_station.sv
source/int_alu.sv
source/ooo_core.sv
dv/ooo_core_properties.sv
dv/tb_ooo_core.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_ooo_core \
  -f build.f -o tb_ooo_core
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/tb_ooo_core +verilator+error+limit+1000 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "TESTS PASSED" "$log"; then
  exit 0
fi
exit 1

// ==== dv/tb_ooo_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ooo_core;

  localparam int HALF_PERIOD = 2;
  localparam int NUM_INSTS = 79;
  // generous budget per instruction for the watchdog
  localparam int CYCLES_PER_INST = 40;

  logic        clk_in = 1'b0;
  logic        rst_n;
  logic        issue_valid;
  logic [31:0] issue_inst;
  logic        issue_ready;
  logic        commit_valid;
  logic [4:0]  commit_rd;
  logic [31:0] commit_value;

  logic [31:0] rng_state = 32'd20;
  // architectural state of the reference model
  logic [31:0] arch_regs [32];
  logic [4:0]  exp_rd_q [$];
  logic [31:0] exp_value_q [$];
  int          commit_idx = 0;
  logic        front_ok = 1'b0;
  logic [4:0]  front_rd = '0;
  logic [31:0] front_value = '0;
  int          errors = 0;
  int          stall_cycles = 0;
  int          test_num = 0;
  int          test_errors_base = 0;

  ooo_core dut_i (
    .clk_in, .rst_n, .issue_valid, .issue_inst, .issue_ready,
    .commit_valid, .commit_rd, .commit_value
  );

  always #HALF_PERIOD clk_in = ~clk_in;

  // xorshift32 step on the shared state
  function automatic logic [31:0] rand32();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic logic [4:0] pick_reg(input int lo, input int n);
    return 5'(lo + int'(rand32() % n));
  endfunction

  // op index in alu_op_e order, imm_form picks OP-IMM
  function automatic logic [31:0] encode(input int op, input logic imm_form,
      input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2,
      input logic [11:0] imm);
    logic [2:0]  f3;
    logic        alt;
    logic [11:0] imm12;
    case (op)
      0, 1:    f3 = 3'b000;
      2:       f3 = 3'b001;
      3:       f3 = 3'b010;
      4:       f3 = 3'b011;
      5:       f3 = 3'b100;
      6, 7:    f3 = 3'b101;
      8:       f3 = 3'b110;
      default: f3 = 3'b111;
    endcase
    alt = (op == 1) || (op == 7);
    imm12 = imm;
    // shift immediates: funct7 on top of a 5-bit shamt
    if (f3 == 3'b001 || f3 == 3'b101) imm12 = {1'b0, alt, 5'b0, imm[4:0]};
    if (imm_form) return {imm12, rs1, f3, rd, tomasulo_pkg::OPCODE_OP_IMM};
    return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, tomasulo_pkg::OPCODE_OP};
  endfunction

  // RV32I result rules
  function automatic logic [31:0] rv32_result(input tomasulo_pkg::alu_op_e op,
      input logic [31:0] a, input logic [31:0] b);
    logic [4:0] sh;
    sh = b[4:0];
    case (op)
      tomasulo_pkg::ALU_ADD:  return a + b;
      tomasulo_pkg::ALU_SUB:  return a - b;
      tomasulo_pkg::ALU_SLL:  return a << sh;
      // differing signs decide it, else plain magnitude
      tomasulo_pkg::ALU_SLT:  return (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
      tomasulo_pkg::ALU_SLTU: return {31'b0, a < b};
      tomasulo_pkg::ALU_XOR:  return a ^ b;
      tomasulo_pkg::ALU_SRL:  return a >> sh;
      // logical shift, then refill vacated top bits with the sign
      tomasulo_pkg::ALU_SRA:  return (a >> sh) | ({32{a[31]}} & ~(32'hffff_ffff >> sh));
      tomasulo_pkg::ALU_OR:   return a | b;
      default:                return a & b;
    endcase
  endfunction

  // executes in program order, queues what must commit
  function automatic void model_accept(input logic [31:0] inst);
    tomasulo_pkg::decoded_t d;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] v;
    d = tomasulo_pkg::decode(inst);
    a = arch_regs[d.rs1];
    b = d.use_imm ? d.imm : arch_regs[d.rs2];
    v = rv32_result(d.op, a, b);
    exp_rd_q.push_back(d.rd);
    exp_value_q.push_back(v);
    if (d.rd != 5'd0) arch_regs[d.rd] = v;
  endfunction

  // called at a falling edge, returns one falling edge after acceptance
  task automatic send(input logic [31:0] inst);
    issue_valid = 1'b1;
    issue_inst = inst;
    // ready is stable from the falling edge up to the next rising edge
    while (!issue_ready) begin
      stall_cycles++;
      @(negedge clk_in);
    end
    model_accept(inst);
    @(negedge clk_in);
    issue_valid = 1'b0;
  endtask

  task automatic send_random(input logic [4:0] rd, input logic [4:0] rs1,
      input logic [4:0] rs2);
    int   op;
    logic imm_form;
    op = int'(rand32() % 10);
    imm_form = (rand32() % 2) == 1;
    // no immediate form of sub
    if (op == 1) imm_form = 1'b0;
    send(encode(op, imm_form, rd, rs1, rs2, 12'(rand32())));
  endtask

  task automatic end_test(input string name);
    while (commit_idx != exp_value_q.size()) @(negedge clk_in);
    // quiet window, a duplicate commit would land here
    repeat (8) @(negedge clk_in);
    test_num++;
    $display("test %0d %s: %0d errors", test_num, name, errors - test_errors_base);
    test_errors_base = errors;
  endtask

  always @(posedge clk_in) begin
    if (rst_n && commit_valid) commit_idx <= commit_idx + 1;
  end

  // head of the expected commit stream, refreshed away from the rising edge
  always @(negedge clk_in) begin
    front_ok = commit_idx < exp_value_q.size();
    if (front_ok) begin
      front_rd = exp_rd_q[commit_idx];
      front_value = exp_value_q[commit_idx];
    end
  end

  commit_expected: assert property (@(posedge clk_in) disable iff (!rst_n)
    commit_valid |-> front_ok)
    else begin
      errors++;
      $display("commit at %0t with no accepted instruction left to retire", $time);
    end

  commit_rd_match: assert property (@(posedge clk_in) disable iff (!rst_n)
    commit_valid && front_ok |-> commit_rd == front_rd)
    else begin
      errors++;
      $display("Fail time=%0t commit_rd expected=%0d actual=%0d", $time,
               $sampled(front_rd), $sampled(commit_rd));
    end

  commit_value_match: assert property (@(posedge clk_in) disable iff (!rst_n)
    commit_valid && front_ok |-> commit_value == front_value)
    else begin
      errors++;
      $display("Fail time=%0t commit_value expected=%h actual=%h", $time,
               $sampled(front_value), $sampled(commit_value));
    end

  initial begin
    #(NUM_INSTS * CYCLES_PER_INST * 2 * HALF_PERIOD);
    $display("watchdog expired before all instructions committed");
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    logic [4:0] prev;
    int         total;
    rst_n = 1'b0;
    issue_valid = 1'b0;
    issue_inst = '0;
    for (int i = 0; i < 32; i++) arch_regs[i] = '0;
    repeat (4) @(negedge clk_in);
    rst_n = 1'b1;
    repeat (6) @(negedge clk_in);
    end_test("reset idle");

    // x1..x8 from sign-extended immediates, both signs
    for (int r = 1; r <= 8; r++) begin
      send(encode(0, 1'b1, 5'(r), 5'd0, 5'd0, 12'(rand32())));
    end
    for (int op = 0; op < 10; op++) begin
      for (int f = 0; f < 2; f++) begin
        if (!(op == 1 && f == 1)) begin
          send(encode(op, f[0], pick_reg(9, 7), pick_reg(1, 8), pick_reg(1, 8),
                      12'(rand32())));
        end
      end
    end
    end_test("alu ops");

    // each link reads the rd just written
    prev = 5'd9;
    for (int i = 0; i < 8; i++) begin
      send_random(5'(16 + i), prev, pick_reg(1, 8));
      prev = 5'(16 + i);
    end
    end_test("dependent chain");

    // random overlap of sources and targets, with idle gaps
    for (int i = 0; i < 24; i++) begin
      send_random(pick_reg(1, 15), pick_reg(1, 15), pick_reg(1, 23));
      if (rand32() % 3 == 0) @(negedge clk_in);
    end
    end_test("mixed order");

    // dependent chain without gaps piles up in the RS
    stall_cycles = 0;
    prev = 5'd24;
    for (int i = 0; i < 16; i++) begin
      send_random(5'(24 + i % 4), prev, pick_reg(1, 8));
      prev = 5'(24 + i % 4);
    end
    stall_seen: assert (stall_cycles > 0) else begin
      errors++;
      $display("issue_ready never dropped during back-to-back issue");
    end
    end_test("back to back");

    send(encode(0, 1'b1, 5'd0, 5'd1, 5'd0, 12'd5));
    send(encode(5, 1'b0, 5'd0, 5'd2, 5'd3, 12'd0));
    send(encode(0, 1'b0, 5'd5, 5'd0, 5'd0, 12'd0));
    send(encode(8, 1'b1, 5'd6, 5'd0, 5'd0, 12'hffd));
    end_test("x0 writes");

    total = errors + dut_i.props_i.violations;
    $display("%0d tests, %0d instructions, %0d commits, %0d errors",
             test_num, exp_value_q.size(), commit_idx, total);
    if (total == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== dv/ooo_core_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

// protocol checks on the issue handshake and the commit port
module ooo_core_properties (
  input logic clk_in,
  input logic rst_n,
  input logic issue_valid,
  input logic issue_ready,
  input logic commit_valid,
  input logic cdb_valid
);

  // accepted but not yet retired
  int in_flight;
  int violations = 0;

  always_ff @(posedge clk_in) begin
    if (!rst_n) begin
      in_flight <= 0;
    end else begin
      in_flight <= in_flight + int'(issue_valid && issue_ready) - int'(commit_valid);
    end
  end

  // first cycle out of reset is open for issue with nothing retiring or broadcasting
  reset_idle: assert property (@(posedge clk_in)
    $rose(rst_n) |-> issue_ready && !commit_valid && !cdb_valid)
    else begin
      violations++;
      $error("core not idle right after reset");
    end

  // only an accepted instruction fills a slot, so raising valid alone never drops ready
  ready_drops_on_accept: assert property (@(posedge clk_in) disable iff (!rst_n)
    !(issue_valid && issue_ready) |=> !$fell(issue_ready))
    else begin
      violations++;
      $error("issue_ready dropped although no instruction was accepted");
    end

  commit_known: assert property (@(posedge clk_in) disable iff (!rst_n)
    !$isunknown(commit_valid))
    else begin
      violations++;
      $error("commit_valid is unknown");
    end

  // an empty ROB has nothing to retire
  no_empty_commit: assert property (@(posedge clk_in) disable iff (!rst_n)
    commit_valid |-> in_flight != 0)
    else begin
      violations++;
      $error("commit while no instruction is in flight");
    end

endmodule

bind ooo_core ooo_core_properties props_i (
  .clk_in(clk_in),
  .rst_n(rst_n),
  .issue_valid(issue_valid),
  .issue_ready(issue_ready),
  .commit_valid(commit_valid),
  .cdb_valid(cdb_valid)
);

`default_nettype wire

// ==== source/ooo_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module ooo_core (
  input  logic                                clk_in,
  input  logic                                rst_n,
  input  logic                                issue_valid,
  input  logic [tomasulo_pkg::XLEN-1:0]       issue_inst,
  output logic                                issue_ready,
  output logic                                commit_valid,
  output logic [tomasulo_pkg::REG_ADDR_W-1:0] commit_rd,
  output logic [tomasulo_pkg::XLEN-1:0]       commit_value
);

  logic                                rob_full;
  logic                                rs_full;
  tomasulo_pkg::rob_id_t               next_rob_id;
  logic [tomasulo_pkg::REG_ADDR_W-1:0] rs1;
  logic [tomasulo_pkg::REG_ADDR_W-1:0] rs2;
  logic [tomasulo_pkg::XLEN-1:0]       rf_vj;
  logic [tomasulo_pkg::XLEN-1:0]       rf_vk;
  logic                                rf_rj;
  logic                                rf_rk;
  tomasulo_pkg::rob_id_t               rf_qj;
  tomasulo_pkg::rob_id_t               rf_qk;
  logic                                fwd_ready_j;
  logic                                fwd_ready_k;
  logic [tomasulo_pkg::XLEN-1:0]       fwd_value_j;
  logic [tomasulo_pkg::XLEN-1:0]       fwd_value_k;
  logic                                cdb_valid;
  tomasulo_pkg::rob_id_t               cdb_rob_id;
  logic [tomasulo_pkg::XLEN-1:0]       cdb_value;
  logic                                rename_en;
  logic [tomasulo_pkg::REG_ADDR_W-1:0] rename_rd;
  logic                                alloc_en;
  tomasulo_pkg::rob_id_t               commit_rob_id;
  logic                                exec_valid;
  tomasulo_pkg::alu_op_e               exec_op;
  logic [tomasulo_pkg::XLEN-1:0]       exec_a;
  logic [tomasulo_pkg::XLEN-1:0]       exec_b;
  tomasulo_pkg::rob_id_t               exec_rob_id;

  dispatch_if disp_bus ();

  issue_unit issue_i (
    .issue_valid, .issue_inst, .issue_ready, .rob_full, .rs_full, .next_rob_id,
    .rs1, .rs2, .vj(rf_vj), .vk(rf_vk), .rj(rf_rj), .rk(rf_rk), .qj(rf_qj), .qk(rf_qk),
    .fwd_ready_j, .fwd_ready_k, .fwd_value_j, .fwd_value_k,
    .cdb_valid, .cdb_rob_id, .cdb_value, .rename_en, .rename_rd, .alloc_en,
    .disp(disp_bus.issuer)
  );

  // renamed rd takes the tag issue just allocated
  rename_regfile regfile_i (
    .clk_in, .rst_n, .rs1, .rs2,
    .vj(rf_vj), .vk(rf_vk), .rj(rf_rj), .rk(rf_rk), .qj(rf_qj), .qk(rf_qk),
    .rename_en, .rename_rd, .rename_rob_id(next_rob_id),
    .commit_valid, .commit_rd, .commit_value, .commit_rob_id
  );

  // rob is queried with the regfile's pending tags
  reorder_buffer rob_i (
    .clk_in, .rst_n, .alloc_en, .alloc_rd(rename_rd), .next_rob_id, .rob_full,
    .cdb_valid, .cdb_rob_id, .cdb_value, .query_j(rf_qj), .query_k(rf_qk),
    .fwd_ready_j, .fwd_ready_k, .fwd_value_j, .fwd_value_k,
    .commit_valid, .commit_rd, .commit_value, .commit_rob_id
  );

  reservation_station rs_i (
    .clk_in, .rst_n, .disp(disp_bus.station), .cdb_valid, .cdb_rob_id, .cdb_value,
    .rs_full, .exec_valid, .exec_op, .exec_a, .exec_b, .exec_rob_id
  );

  int_alu alu_i (
    .clk_in, .rst_n, .exec_valid, .exec_op, .exec_a, .exec_b, .exec_rob_id,
    .cdb_valid, .cdb_rob_id, .cdb_value
  );

endmodule

`default_nettype wire

// ==== source/int_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module int_alu (
  input  logic                          clk_in,
  input  logic                          rst_n,
  input  logic                          exec_valid,
  input  tomasulo_pkg::alu_op_e         exec_op,
  input  logic [tomasulo_pkg::XLEN-1:0] exec_a,
  input  logic [tomasulo_pkg::XLEN-1:0] exec_b,
  input  tomasulo_pkg::rob_id_t         exec_rob_id,
  output logic                          cdb_valid,
  output tomasulo_pkg::rob_id_t         cdb_rob_id,
  output logic [tomasulo_pkg::XLEN-1:0] cdb_value
);

  logic [tomasulo_pkg::XLEN-1:0] result;
  logic [4:0]                    shamt;

  // shifts only look at the low five bits
  assign shamt = exec_b[4:0];

  always_comb begin
    case (exec_op)
      tomasulo_pkg::ALU_ADD:  result = exec_a + exec_b;
      tomasulo_pkg::ALU_SUB:  result = exec_a - exec_b;
      tomasulo_pkg::ALU_SLL:  result = exec_a << shamt;
      tomasulo_pkg::ALU_SLT:  result = {31'b0, $signed(exec_a) < $signed(exec_b)};
      tomasulo_pkg::ALU_SLTU: result = {31'b0, exec_a < exec_b};
      tomasulo_pkg::ALU_XOR:  result = exec_a ^ exec_b;
      tomasulo_pkg::ALU_SRL:  result = exec_a >> shamt;
      tomasulo_pkg::ALU_SRA:  result = $unsigned($signed(exec_a) >>> shamt);
      tomasulo_pkg::ALU_OR:   result = exec_a | exec_b;
      default:                result = exec_a & exec_b;
    endcase
  end

  // one cycle from select to broadcast
  always_ff @(posedge clk_in) begin
    if (!rst_n) begin
      cdb_valid <= 1'b0;
    end else begin
      cdb_valid <= exec_valid;
    end
  end

  always_ff @(posedge clk_in) begin
    cdb_rob_id <= exec_rob_id;
    cdb_value  <= result;
  end

endmodule

`default_nettype wire

// ==== source/reservation_station.sv ====
`timescale 1ns/1ps
`default_nettype none

module reservation_station (
  input  logic                          clk_in,
  input  logic                          rst_n,
  dispatch_if.station                   disp,
  input  logic                          cdb_valid,
  input  tomasulo_pkg::rob_id_t         cdb_rob_id,
  input  logic [tomasulo_pkg::XLEN-1:0] cdb_value,
  output logic                          rs_full,
  output logic                          exec_valid,
  output tomasulo_pkg::alu_op_e         exec_op,
  output logic [tomasulo_pkg::XLEN-1:0] exec_a,
  output logic [tomasulo_pkg::XLEN-1:0] exec_b,
  output tomasulo_pkg::rob_id_t         exec_rob_id
);

  localparam int N = tomasulo_pkg::RS_DEPTH;

  logic [N-1:0]                  valid_q;
  tomasulo_pkg::alu_op_e         op_q  [N];
  logic [tomasulo_pkg::XLEN-1:0] vj_q  [N];
  logic [tomasulo_pkg::XLEN-1:0] vk_q  [N];
  tomasulo_pkg::rob_id_t         qj_q  [N];
  tomasulo_pkg::rob_id_t         qk_q  [N];
  logic                          rj_q  [N];
  logic                          rk_q  [N];
  tomasulo_pkg::rob_id_t         rob_q [N];
  // older_q[j][i] set when entry j arrived before entry i
  logic [N-1:0]                  older_q [N];
  logic [N-1:0]                  ready_w;
  logic                          sel_any;
  int                            sel_idx;
  int                            free_idx;

  assign rs_full = &valid_q;

  always_comb begin
    for (int i = 0; i < N; i++) begin
      ready_w[i] = valid_q[i] && rj_q[i] && rk_q[i];
    end
  end

  // lowest free slot for the incoming instruction
  always_comb begin
    free_idx = 0;
    for (int i = N - 1; i >= 0; i--) begin
      if (!valid_q[i]) free_idx = i;
    end
  end

  // oldest ready entry, nothing older may also be ready
  always_comb begin
    logic blocked;
    sel_any = 1'b0;
    sel_idx = 0;
    for (int i = 0; i < N; i++) begin
      blocked = 1'b0;
      for (int j = 0; j < N; j++) begin
        if (ready_w[j] && older_q[j][i]) blocked = 1'b1;
      end
      if (ready_w[i] && !blocked && !sel_any) begin
        sel_any = 1'b1;
        sel_idx = i;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (!rst_n) begin
      valid_q    <= '0;
      exec_valid <= 1'b0;
    end else begin
      exec_valid <= sel_any;
      if (sel_any) valid_q[sel_idx] <= 1'b0;
      if (disp.valid) valid_q[free_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk_in) begin
    // cdb wake-up of waiting operands
    for (int i = 0; i < N; i++) begin
      if (cdb_valid && !rj_q[i] && qj_q[i] == cdb_rob_id) begin
        vj_q[i] <= cdb_value;
        rj_q[i] <= 1'b1;
      end
      if (cdb_valid && !rk_q[i] && qk_q[i] == cdb_rob_id) begin
        vk_q[i] <= cdb_value;
        rk_q[i] <= 1'b1;
      end
    end
    if (disp.valid) begin
      op_q[free_idx]  <= disp.op;
      vj_q[free_idx]  <= disp.vj;
      qj_q[free_idx]  <= disp.qj;
      rj_q[free_idx]  <= disp.rj;
      // immediate form carries imm as second operand
      vk_q[free_idx]  <= disp.use_imm ? disp.imm : disp.vk;
      qk_q[free_idx]  <= disp.qk;
      rk_q[free_idx]  <= disp.rk || disp.use_imm;
      rob_q[free_idx] <= disp.rob_id;
      // newcomer is younger than everyone, row write wins on the diagonal
      for (int j = 0; j < N; j++) begin
        older_q[j][free_idx] <= 1'b1;
      end
      older_q[free_idx] <= '0;
    end
    exec_op     <= op_q[sel_idx];
    exec_a      <= vj_q[sel_idx];
    exec_b      <= vk_q[sel_idx];
    exec_rob_id <= rob_q[sel_idx];
  end

endmodule

`default_nettype wire

// ==== source/reorder_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer (
  input  logic                                clk_in,
  input  logic                                rst_n,
  input  logic                                alloc_en,
  input  logic [tomasulo_pkg::REG_ADDR_W-1:0] alloc_rd,
  output tomasulo_pkg::rob_id_t               next_rob_id,
  output logic                                rob_full,
  input  logic                                cdb_valid,
  input  tomasulo_pkg::rob_id_t               cdb_rob_id,
  input  logic [tomasulo_pkg::XLEN-1:0]       cdb_value,
  input  tomasulo_pkg::rob_id_t               query_j,
  input  tomasulo_pkg::rob_id_t               query_k,
  output logic                                fwd_ready_j,
  output logic                                fwd_ready_k,
  output logic [tomasulo_pkg::XLEN-1:0]       fwd_value_j,
  output logic [tomasulo_pkg::XLEN-1:0]       fwd_value_k,
  output logic                                commit_valid,
  output logic [tomasulo_pkg::REG_ADDR_W-1:0] commit_rd,
  output logic [tomasulo_pkg::XLEN-1:0]       commit_value,
  output tomasulo_pkg::rob_id_t               commit_rob_id
);

  tomasulo_pkg::rob_id_t                 head_q;
  tomasulo_pkg::rob_id_t                 tail_q;
  logic [tomasulo_pkg::ROB_ID_W:0]       count_q;
  logic                                  ready_q [tomasulo_pkg::ROB_DEPTH];
  logic [tomasulo_pkg::REG_ADDR_W-1:0]   rd_q    [tomasulo_pkg::ROB_DEPTH];
  logic [tomasulo_pkg::XLEN-1:0]         value_q [tomasulo_pkg::ROB_DEPTH];

  // new entries always land at the tail
  assign next_rob_id = tail_q;
  assign rob_full = (count_q == tomasulo_pkg::ROB_DEPTH);

  // results already captured but not yet retired
  assign fwd_ready_j = ready_q[query_j];
  assign fwd_value_j = value_q[query_j];
  assign fwd_ready_k = ready_q[query_k];
  assign fwd_value_k = value_q[query_k];

  // head retires the cycle after its result landed
  assign commit_valid = (count_q != '0) && ready_q[head_q];
  assign commit_rd = rd_q[head_q];
  assign commit_value = value_q[head_q];
  assign commit_rob_id = head_q;

  always_ff @(posedge clk_in) begin
    if (!rst_n) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
      for (int i = 0; i < tomasulo_pkg::ROB_DEPTH; i++) begin
        ready_q[i] <= 1'b0;
      end
    end else begin
      if (cdb_valid) begin
        ready_q[cdb_rob_id] <= 1'b1;
      end
      if (alloc_en) begin
        ready_q[tail_q] <= 1'b0;
        tail_q <= tail_q + 1'b1;
      end
      if (commit_valid) begin
        head_q <= head_q + 1'b1;
      end
      // one in, one out leaves the count alone
      count_q <= count_q + alloc_en - commit_valid;
    end
  end

  // entry payload
  always_ff @(posedge clk_in) begin
    if (alloc_en) begin
      rd_q[tail_q] <= alloc_rd;
    end
    if (cdb_valid) begin
      value_q[cdb_rob_id] <= cdb_value;
    end
  end

endmodule

`default_nettype wire

// ==== source/rename_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module rename_regfile (
  input  logic                                clk_in,
  input  logic                                rst_n,
  input  logic [tomasulo_pkg::REG_ADDR_W-1:0] rs1,
  input  logic [tomasulo_pkg::REG_ADDR_W-1:0] rs2,
  output logic [tomasulo_pkg::XLEN-1:0]       vj,
  output logic [tomasulo_pkg::XLEN-1:0]       vk,
  output logic                                rj,
  output logic                                rk,
  output tomasulo_pkg::rob_id_t               qj,
  output tomasulo_pkg::rob_id_t               qk,
  input  logic                                rename_en,
  input  logic [tomasulo_pkg::REG_ADDR_W-1:0] rename_rd,
  input  tomasulo_pkg::rob_id_t               rename_rob_id,
  input  logic                                commit_valid,
  input  logic [tomasulo_pkg::REG_ADDR_W-1:0] commit_rd,
  input  logic [tomasulo_pkg::XLEN-1:0]       commit_value,
  input  tomasulo_pkg::rob_id_t               commit_rob_id
);

  localparam int NREGS = 2 ** tomasulo_pkg::REG_ADDR_W;

  logic [tomasulo_pkg::XLEN-1:0] regs_q [NREGS];
  logic                          busy_q [NREGS];
  tomasulo_pkg::rob_id_t         tag_q  [NREGS];

  // lookups are combinational, busy means value still in flight
  assign vj = regs_q[rs1];
  assign vk = regs_q[rs2];
  assign rj = !busy_q[rs1];
  assign rk = !busy_q[rs2];
  assign qj = tag_q[rs1];
  assign qk = tag_q[rs2];

  always_ff @(posedge clk_in) begin
    if (!rst_n) begin
      for (int i = 0; i < NREGS; i++) begin
        regs_q[i] <= '0;
        busy_q[i] <= 1'b0;
        tag_q[i]  <= '0;
      end
    end else begin
      if (commit_valid && commit_rd != '0) begin
        regs_q[commit_rd] <= commit_value;
        // only the youngest producer frees the register
        if (tag_q[commit_rd] == commit_rob_id) begin
          busy_q[commit_rd] <= 1'b0;
        end
      end
      // rename comes last so a same-cycle commit keeps the new tag
      if (rename_en) begin
        busy_q[rename_rd] <= 1'b1;
        tag_q[rename_rd]  <= rename_rob_id;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/issue_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_unit (
  input  logic                                issue_valid,
  input  logic [tomasulo_pkg::XLEN-1:0]       issue_inst,
  output logic                                issue_ready,
  input  logic                                rob_full,
  input  logic                                rs_full,
  input  tomasulo_pkg::rob_id_t               next_rob_id,
  output logic [tomasulo_pkg::REG_ADDR_W-1:0] rs1,
  output logic [tomasulo_pkg::REG_ADDR_W-1:0] rs2,
  input  logic [tomasulo_pkg::XLEN-1:0]       vj,
  input  logic [tomasulo_pkg::XLEN-1:0]       vk,
  input  logic                                rj,
  input  logic                                rk,
  input  tomasulo_pkg::rob_id_t               qj,
  input  tomasulo_pkg::rob_id_t               qk,
  input  logic                                fwd_ready_j,
  input  logic                                fwd_ready_k,
  input  logic [tomasulo_pkg::XLEN-1:0]       fwd_value_j,
  input  logic [tomasulo_pkg::XLEN-1:0]       fwd_value_k,
  input  logic                                cdb_valid,
  input  tomasulo_pkg::rob_id_t               cdb_rob_id,
  input  logic [tomasulo_pkg::XLEN-1:0]       cdb_value,
  output logic                                rename_en,
  output logic [tomasulo_pkg::REG_ADDR_W-1:0] rename_rd,
  output logic                                alloc_en,
  dispatch_if.issuer                          disp
);

  tomasulo_pkg::decoded_t d;
  logic                   fire;

  // operand priority is regfile then rob then live cdb then a wait on the tag
  function automatic logic [tomasulo_pkg::XLEN:0] resolve(
    input logic [tomasulo_pkg::REG_ADDR_W-1:0] idx,
    input logic                                rf_ready,
    input logic [tomasulo_pkg::XLEN-1:0]       rf_value,
    input tomasulo_pkg::rob_id_t               tag,
    input logic                                rob_ready,
    input logic [tomasulo_pkg::XLEN-1:0]       rob_value
  );
    if (idx == '0) begin
      return {1'b1, {tomasulo_pkg::XLEN{1'b0}}};
    end else if (rf_ready) begin
      return {1'b1, rf_value};
    end else if (rob_ready) begin
      return {1'b1, rob_value};
    end else if (cdb_valid && cdb_rob_id == tag) begin
      return {1'b1, cdb_value};
    end
    return {1'b0, {tomasulo_pkg::XLEN{1'b0}}};
  endfunction

  assign d = tomasulo_pkg::decode(issue_inst);
  assign rs1 = d.rs1;
  assign rs2 = d.rs2;

  // built from registered full flags and never from issue_valid
  assign issue_ready = !rob_full && !rs_full;
  assign fire = issue_valid && issue_ready;

  // every accepted instruction gets a rob slot but x0 is never renamed
  assign alloc_en = fire;
  assign rename_en = fire && (d.rd != '0);
  assign rename_rd = d.rd;

  assign disp.valid = fire;
  assign disp.op = d.op;
  assign {disp.rj, disp.vj} = resolve(d.rs1, rj, vj, qj, fwd_ready_j, fwd_value_j);
  assign {disp.rk, disp.vk} = resolve(d.rs2, rk, vk, qk, fwd_ready_k, fwd_value_k);
  assign disp.qj = qj;
  assign disp.qk = qk;
  assign disp.imm = d.imm;
  assign disp.use_imm = d.use_imm;
  assign disp.rob_id = next_rob_id;

endmodule

`default_nettype wire

// ==== source/dispatch_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// renamed instruction from issue into the reservation station
interface dispatch_if;
  logic                            valid;
  tomasulo_pkg::alu_op_e           op;
  // r = value ready, q = producer tag while waiting
  logic [tomasulo_pkg::XLEN-1:0]   vj;
  tomasulo_pkg::rob_id_t           qj;
  logic                            rj;
  logic [tomasulo_pkg::XLEN-1:0]   vk;
  tomasulo_pkg::rob_id_t           qk;
  logic                            rk;
  logic [tomasulo_pkg::XLEN-1:0]   imm;
  logic                            use_imm;
  tomasulo_pkg::rob_id_t           rob_id;

  modport issuer (output valid, op, vj, qj, rj, vk, qk, rk, imm, use_imm, rob_id);
  modport station (input valid, op, vj, qj, rj, vk, qk, rk, imm, use_imm, rob_id);
endinterface

`default_nettype wire

// ==== source/tomasulo_pkg.sv ====
`default_nettype none

package tomasulo_pkg;

  // datapath and queue sizes
  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int ROB_DEPTH  = 8;
  localparam int ROB_ID_W   = 3;
  localparam int RS_DEPTH   = 4;

  // the only two major opcodes handled by the engine
  localparam logic [6:0] OPCODE_OP     = 7'b0110011;
  localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;

  typedef logic [ROB_ID_W-1:0] rob_id_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_e;

  typedef struct packed {
    alu_op_e               op;
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [XLEN-1:0]       imm;
    logic                  use_imm;
  } decoded_t;

  // OP / OP-IMM decode, other opcodes give an undefined mix
  function automatic decoded_t decode(input logic [XLEN-1:0] inst);
    decoded_t d;
    logic     alt;
    d.use_imm = (inst[6:0] == OPCODE_OP_IMM);
    d.rd      = inst[11:7];
    d.rs1     = inst[19:15];
    // immediate form reads x0 on the second port, so it is always ready
    d.rs2     = d.use_imm ? '0 : inst[24:20];
    d.imm     = {{(XLEN-12){inst[31]}}, inst[31:20]};
    // funct7 bit 30 picks sub and sra
    alt       = inst[30];
    case (inst[14:12])
      3'b000:  d.op = (alt && !d.use_imm) ? ALU_SUB : ALU_ADD;
      3'b001:  d.op = ALU_SLL;
      3'b010:  d.op = ALU_SLT;
      3'b011:  d.op = ALU_SLTU;
      3'b100:  d.op = ALU_XOR;
      3'b101:  d.op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  d.op = ALU_OR;
      default: d.op = ALU_AND;
    endcase
    return d;
  endfunction

endpackage

`default_nettype wire
